// ==== common/glm_pkg.sv ====
package glm_pkg;

    localparam int lanes_per_line = 4;
    localparam int lane_width = 16;
    localparam int frac_bits = 12;
    localparam int addr_width = 10;
    localparam int fifo_depth = 8;

    // one Q4.12 lane.
    typedef logic signed [lane_width-1:0] lane_t;

    // the memory ports move raw words while the datapath works on lanes.
    // lane 0 occupies the low bits.
    typedef union packed {
        logic [lanes_per_line*lane_width-1:0] raw;
        lane_t [lanes_per_line-1:0]           lanes;
    } line_t;

    typedef logic [addr_width-1:0] addr_t;

    typedef struct packed {
        logic [15:0] num_lines;
        logic [15:0] num_iterations;
        addr_t       left_base;
        addr_t       right_base;
        addr_t       out_base;
        logic        do_sigmoid;
    } delta_cmd_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        line_t data;
    } mem_wr_t;

endpackage

// ==== compile.f ====
common/glm_pkg.sv
design/line_fifo.sv
design/region_reader.sv
design/vector_sigmoid.sv
design/vector_subtract.sv
glm_delta/region_writer.sv
glm_delta/glm_delta.sv
design/glm_delta_top.sv
sim/glm_delta_sva.sv
sim/tb_glm_delta.sv

// ==== design/glm_delta_top.sv ====
module glm_delta_top
    import glm_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    output logic        ack,
    input  delta_cmd_t  cmd,
    output mem_rd_req_t left_rd,
    input  line_t       left_rdata,
    output mem_rd_req_t right_rd,
    input  line_t       right_rdata,
    output mem_wr_t     delta_wr
);

    glm_delta delta_i (
        .clk,
        .reset,
        .req,
        .ack,
        .cmd,
        .left_rd,
        .left_rdata,
        .right_rd,
        .right_rdata,
        .delta_wr
    );

endmodule

// ==== design/line_fifo.sv ====
module line_fifo
    import glm_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  line_t      push_data,
    input  logic       pop,
    output line_t      head,
    output logic       empty,
    output logic [3:0] count
);

    line_t mem [fifo_depth];

    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth)-1:0] rd_ptr;

    // pointers wrap naturally since the depth is a power of two.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {3'b000, push} - {3'b000, pop};
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    // the head is read straight from the array, so a push shows up next cycle.
    assign head  = mem[rd_ptr];
    assign empty = (count == 4'd0);

endmodule

// ==== design/region_reader.sv ====
module region_reader
    import glm_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  addr_t       base,
    input  logic [15:0] num_lines,
    input  logic [15:0] num_iterations,
    input  logic [3:0]  fifo_count,
    output mem_rd_req_t rd,
    input  line_t       rdata,
    output logic        line_valid,
    output line_t       line
);

    logic        active;
    addr_t       addr;
    logic [15:0] line_idx;
    logic [15:0] iter_idx;
    logic        issue;
    logic [4:0]  credit_used;

    // at most one read is outstanding, and it is the one now on line_valid.
    assign credit_used = {1'b0, fifo_count} + {4'b0000, line_valid};
    assign issue       = active && (credit_used < fifo_depth);

    assign rd = '{en: issue, addr: addr};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active     <= 1'b0;
            line_valid <= 1'b0;
        end
        else
        begin
            line_valid <= issue;
            if (start)
            begin
                active   <= (num_lines != 16'd0) && (num_iterations != 16'd0);
                addr     <= base;
                line_idx <= 16'd0;
                iter_idx <= 16'd0;
            end
            else if (issue)
            begin
                if (line_idx == num_lines - 16'd1)
                begin
                    // every iteration rereads the same region.
                    line_idx <= 16'd0;
                    addr     <= base;
                    iter_idx <= iter_idx + 16'd1;
                    if (iter_idx == num_iterations - 16'd1)
                    begin
                        active <= 1'b0;
                    end
                end
                else
                begin
                    line_idx <= line_idx + 16'd1;
                    addr     <= addr + 1'b1;
                end
            end
        end
    end

    // memory answers one cycle after the request, which lines up with line_valid.
    assign line.raw = rdata.raw;

endmodule

// ==== design/vector_sigmoid.sv ====
module vector_sigmoid
    import glm_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  enable,
    input  logic  in_valid,
    input  line_t in_line,
    output logic  out_valid,
    output line_t out_line
);

    logic  s1_valid;
    logic  s1_bypass;
    line_t s1_line;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        // stage one forms x/4 + 0.5, which cannot overflow a lane.
        s1_bypass <= !enable;
        for (int i = 0; i < lanes_per_line; i++)
        begin
            if (enable)
            begin
                s1_line.lanes[i] <= (in_line.lanes[i] >>> 2) + lane_t'(1 << (frac_bits - 1));
            end
            else
            begin
                s1_line.lanes[i] <= in_line.lanes[i];
            end
        end

        // stage two clamps to the range zero to one.
        for (int i = 0; i < lanes_per_line; i++)
        begin
            if (s1_bypass)
            begin
                out_line.lanes[i] <= s1_line.lanes[i];
            end
            else if (s1_line.lanes[i] < 0)
            begin
                out_line.lanes[i] <= '0;
            end
            else if (s1_line.lanes[i] > lane_t'(1 << frac_bits))
            begin
                out_line.lanes[i] <= lane_t'(1 << frac_bits);
            end
            else
            begin
                out_line.lanes[i] <= s1_line.lanes[i];
            end
        end
    end

endmodule

// ==== design/vector_subtract.sv ====
module vector_subtract
    import glm_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  in_valid,
    input  line_t minuend,
    input  line_t subtrahend,
    output logic  out_valid,
    output line_t out_line
);

    logic signed [lane_width:0] diff [lanes_per_line];
    line_t                      sat_line;

    always_comb
    begin
        for (int i = 0; i < lanes_per_line; i++)
        begin
            diff[i] = {minuend.lanes[i][lane_width-1], minuend.lanes[i]}
                    - {subtrahend.lanes[i][lane_width-1], subtrahend.lanes[i]};
            // the top two bits differ only when the result left the lane range.
            if (diff[i][lane_width] != diff[i][lane_width-1])
            begin
                sat_line.lanes[i] = diff[i][lane_width] ? {1'b1, {(lane_width-1){1'b0}}}
                                                        : {1'b0, {(lane_width-1){1'b1}}};
            end
            else
            begin
                sat_line.lanes[i] = diff[i][lane_width-1:0];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        out_line <= sat_line;
    end

endmodule

// ==== glm_delta/glm_delta.sv ====
module glm_delta
    import glm_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    output logic        ack,
    input  delta_cmd_t  cmd,
    output mem_rd_req_t left_rd,
    input  line_t       left_rdata,
    output mem_rd_req_t right_rd,
    input  line_t       right_rdata,
    output mem_wr_t     delta_wr
);

    typedef enum logic [1:0]
    {
        state_idle,
        state_process,
        state_done
    } state_t;

    state_t      state;
    delta_cmd_t  cmd_q;
    logic [31:0] total_lines;
    logic [31:0] lines_written;
    logic        start;

    logic        left_valid;
    line_t       left_line;
    logic        right_valid;
    line_t       right_line;
    logic        sig_stage1;
    logic        sig_valid;
    line_t       sig_line;
    line_t       left_head;
    line_t       right_head;
    logic        left_empty;
    logic        right_empty;
    logic [3:0]  left_count;
    logic [3:0]  right_count;
    logic [3:0]  left_credit;
    logic        pop;
    logic        sub_valid;
    line_t       sub_line;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= state_idle;
            ack        <= 1'b0;
            start      <= 1'b0;
            sig_stage1 <= 1'b0;
        end
        else
        begin
            start      <= 1'b0;
            sig_stage1 <= left_valid;
            case (state)
                state_idle:
                begin
                    if (req && !ack)
                    begin
                        cmd_q         <= cmd;
                        total_lines   <= cmd.num_lines * cmd.num_iterations;
                        lines_written <= 32'd0;
                        start         <= 1'b1;
                        state         <= state_process;
                    end
                end
                state_process:
                begin
                    if (delta_wr.en)
                    begin
                        lines_written <= lines_written + 32'd1;
                    end
                    // an empty command completes on the first pass through here.
                    if (lines_written == total_lines)
                    begin
                        ack   <= 1'b1;
                        state <= state_done;
                    end
                end
                state_done:
                begin
                    if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= state_idle;
                    end
                end
                default:
                begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // lines inside the sigmoid still need room in the left FIFO.
    // sig_stage1 mirrors the first valid stage of the sigmoid pipeline.
    assign left_credit = left_count + {3'b000, sig_stage1} + {3'b000, sig_valid};

    region_reader left_reader_i (
        .clk, .reset,
        .start,
        .base(cmd_q.left_base),
        .num_lines(cmd_q.num_lines),
        .num_iterations(cmd_q.num_iterations),
        .fifo_count(left_credit),
        .rd(left_rd),
        .rdata(left_rdata),
        .line_valid(left_valid),
        .line(left_line)
    );

    region_reader right_reader_i (
        .clk, .reset,
        .start,
        .base(cmd_q.right_base),
        .num_lines(cmd_q.num_lines),
        .num_iterations(cmd_q.num_iterations),
        .fifo_count(right_count),
        .rd(right_rd),
        .rdata(right_rdata),
        .line_valid(right_valid),
        .line(right_line)
    );

    vector_sigmoid sigmoid_i (
        .clk, .reset,
        .enable(cmd_q.do_sigmoid),
        .in_valid(left_valid),
        .in_line(left_line),
        .out_valid(sig_valid),
        .out_line(sig_line)
    );

    line_fifo left_fifo_i (
        .clk, .reset,
        .push(sig_valid),
        .push_data(sig_line),
        .pop,
        .head(left_head),
        .empty(left_empty),
        .count(left_count)
    );

    line_fifo right_fifo_i (
        .clk, .reset,
        .push(right_valid),
        .push_data(right_line),
        .pop,
        .head(right_head),
        .empty(right_empty),
        .count(right_count)
    );

    // the write port never stalls, so a pair is taken as soon as both exist.
    assign pop = !left_empty && !right_empty;

    vector_subtract subtract_i (
        .clk, .reset,
        .in_valid(pop),
        .minuend(left_head),
        .subtrahend(right_head),
        .out_valid(sub_valid),
        .out_line(sub_line)
    );

    region_writer writer_i (
        .clk, .reset,
        .start,
        .base(cmd_q.out_base),
        .in_valid(sub_valid),
        .in_line(sub_line),
        .wr(delta_wr)
    );

endmodule

// ==== glm_delta/region_writer.sv ====
module region_writer
    import glm_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  addr_t   base,
    input  logic    in_valid,
    input  line_t   in_line,
    output mem_wr_t wr
);

    addr_t next_addr;
    logic  wr_en_q;
    addr_t wr_addr_q;
    line_t wr_data_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_en_q <= 1'b0;
        end
        else
        begin
            wr_en_q <= in_valid;
        end
    end

    // addresses keep counting across iterations and wrap at the top of memory.
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            next_addr <= base;
        end
        else if (in_valid)
        begin
            next_addr <= next_addr + 1'b1;
            wr_addr_q <= next_addr;
            wr_data_q <= in_line;
        end
    end

    assign wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" && rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_glm_delta \
    > build.log 2>&1 &&
./obj_dir/Vtb_glm_delta > sim.log 2>&1
grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== sim/glm_delta_sva.sv ====
module glm_delta_sva
    import glm_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       req,
    input logic       ack,
    input mem_wr_t    delta_wr,
    input logic [3:0] left_count,
    input logic [3:0] right_count
);

    // the four-phase handshake only releases ack once req is gone.
    ack_release: assert property (@(posedge clk) disable iff (reset)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    // every delta line is written before completion is signalled.
    no_write_after_ack: assert property (@(posedge clk) disable iff (reset)
        ack |-> !delta_wr.en)
        else $error("write seen while ack is high");

    left_fifo_bound: assert property (@(posedge clk) disable iff (reset)
        left_count <= 4'(fifo_depth))
        else $error("left FIFO count above its depth");

    right_fifo_bound: assert property (@(posedge clk) disable iff (reset)
        right_count <= 4'(fifo_depth))
        else $error("right FIFO count above its depth");

endmodule

bind glm_delta_top glm_delta_sva sva_i (
    .clk,
    .reset,
    .req,
    .ack,
    .delta_wr,
    .left_count(delta_i.left_count),
    .right_count(delta_i.right_count)
);

// ==== sim/tb_glm_delta.sv ====
module tb_glm_delta;
    import glm_pkg::*;

    localparam int clk_period = 40;
    localparam int drive_delay = 5;
    localparam int mem_lines = 1 << addr_width;
    localparam int ack_timeout = 400;
    // summed line counts of all tests, used to size the watchdog.
    localparam int total_test_lines = 12 + 12 + 24 + 2 + 0 + 6 + 6;
    localparam int watchdog_cycles = total_test_lines * 20 + 400;

    logic        clk;
    logic        reset;
    logic        req;
    logic        ack;
    delta_cmd_t  cmd;
    mem_rd_req_t left_rd;
    mem_rd_req_t right_rd;
    line_t       left_rdata;
    line_t       right_rdata;
    mem_wr_t     delta_wr;

    line_t       left_mem [mem_lines];
    line_t       right_mem [mem_lines];
    line_t       out_mem [mem_lines];
    mem_rd_req_t left_req_q;
    mem_rd_req_t right_req_q;
    logic [31:0] lfsr_state;
    int          write_count;
    int          read_count;
    int          error_count;
    int          tests_run;
    int          tests_passed;

    glm_delta_top dut_i (
        .clk,
        .reset,
        .req,
        .ack,
        .cmd,
        .left_rd,
        .left_rdata,
        .right_rd,
        .right_rdata,
        .delta_wr
    );

    always #(clk_period / 2) clk = ~clk;

    // three memories whose reads answer one cycle after the request.
    always @(posedge clk)
    begin
        left_req_q  = left_rd;
        right_req_q = right_rd;
        if (left_req_q.en === 1'b1)
        begin
            read_count++;
        end
        if (right_req_q.en === 1'b1)
        begin
            read_count++;
        end
        if (delta_wr.en === 1'b1)
        begin
            out_mem[delta_wr.addr] = delta_wr.data;
            write_count++;
        end
        #drive_delay;
        if (left_req_q.en === 1'b1)
        begin
            left_rdata = left_mem[left_req_q.addr];
        end
        if (right_req_q.en === 1'b1)
        begin
            right_rdata = right_mem[right_req_q.addr];
        end
    end

    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("watchdog: the run did not finish within %0d cycles", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_line(output line_t l);
        for (int b = 0; b < lanes_per_line * lane_width; b++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            l.raw[b] = lfsr_state[0];
        end
    endtask

    function automatic line_t fill_pattern(input addr_t a);
        line_t l;
        l.raw = {4{6'h2a, a}};
        return l;
    endfunction

    function automatic line_t make_line(input int l0, input int l1, input int l2, input int l3);
        line_t l;
        l.lanes[0] = lane_t'(l0);
        l.lanes[1] = lane_t'(l1);
        l.lanes[2] = lane_t'(l2);
        l.lanes[3] = lane_t'(l3);
        return l;
    endfunction

    function automatic lane_t sat_sub(input lane_t a, input lane_t b);
        int d;
        d = int'(a) - int'(b);
        if (d > 32767)
        begin
            d = 32767;
        end
        else if (d < -32768)
        begin
            d = -32768;
        end
        return lane_t'(d);
    endfunction

    // one half plus a quarter of x, clamped to zero and one.
    function automatic lane_t hard_sigmoid(input lane_t x);
        int v;
        v = (int'(x) >>> 2) + (1 << (frac_bits - 1));
        if (v < 0)
        begin
            v = 0;
        end
        else if (v > (1 << frac_bits))
        begin
            v = 1 << frac_bits;
        end
        return lane_t'(v);
    endfunction

    function automatic line_t expected_delta(input line_t left, input line_t right, input logic sig);
        line_t r;
        lane_t a;
        for (int i = 0; i < lanes_per_line; i++)
        begin
            a = sig ? hard_sigmoid(left.lanes[i]) : left.lanes[i];
            r.lanes[i] = sat_sub(a, right.lanes[i]);
        end
        return r;
    endfunction

    task automatic check_line(input line_t expected, input line_t actual, input string what);
        if (actual !== expected)
        begin
            $display("Fail at time %0t: %s, expected %h, got %h", $time, what,
                     expected.raw, actual.raw);
            error_count++;
        end
    endtask

    task automatic check_ack(input logic expected, input logic actual, input string what);
        if (actual !== expected)
        begin
            $display("Fail at time %0t: %s, expected ack %b, got %b", $time, what,
                     expected, actual);
            error_count++;
        end
    endtask

    task automatic check_count(input int expected, input int actual, input string what);
        if (actual != expected)
        begin
            $display("Fail at time %0t: %s, expected %0d, got %0d", $time, what,
                     expected, actual);
            error_count++;
        end
    endtask

    // all driving and sampling happens a short delay after the rising edge.
    task automatic step_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic wait_for_ack(input logic level);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < ack_timeout)
        begin
            step_cycle();
            cycles++;
        end
        if (ack !== level)
        begin
            $display("ack did not go to %b within %0d cycles at time %0t", level,
                     ack_timeout, $time);
            error_count++;
        end
    endtask

    task automatic run_command(input delta_cmd_t next_cmd, input int hold_cycles);
        cmd = next_cmd;
        req = 1'b1;
        wait_for_ack(1'b1);
        repeat (hold_cycles)
        begin
            step_cycle();
            check_ack(1'b1, ack, "ack held while req is high");
        end
        req = 1'b0;
        wait_for_ack(1'b0);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before)
        begin
            tests_passed++;
            $display("test %s done, no errors", name);
        end
        else
        begin
            $display("test %s done, %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_bypass();
        int errors_before;
        int writes_before;
        int reads_before;
        errors_before = error_count;
        writes_before = write_count;
        reads_before  = read_count;
        run_command('{num_lines: 12, num_iterations: 1, left_base: 0, right_base: 100,
                      out_base: 200, do_sigmoid: 1'b0}, 1);
        for (int j = 0; j < 12; j++)
        begin
            check_line(expected_delta(left_mem[j], right_mem[100 + j], 1'b0),
                       out_mem[200 + j], "bypass delta line");
        end
        check_line(fill_pattern(10'd212), out_mem[212], "line past the bypass region");
        check_count(12, write_count - writes_before, "bypass write count");
        // each of the two read ports fetches every line once.
        check_count(24, read_count - reads_before, "bypass read count");
        finish_test("bypass", errors_before);
    endtask

    task automatic test_sigmoid();
        int errors_before;
        errors_before = error_count;
        run_command('{num_lines: 12, num_iterations: 1, left_base: 20, right_base: 120,
                      out_base: 230, do_sigmoid: 1'b1}, 1);
        for (int j = 0; j < 12; j++)
        begin
            check_line(expected_delta(left_mem[20 + j], right_mem[120 + j], 1'b1),
                       out_mem[230 + j], "sigmoid delta line");
        end
        finish_test("sigmoid", errors_before);
    endtask

    task automatic test_iterations();
        int errors_before;
        int writes_before;
        errors_before = error_count;
        writes_before = write_count;
        run_command('{num_lines: 8, num_iterations: 3, left_base: 40, right_base: 140,
                      out_base: 260, do_sigmoid: 1'b0}, 1);
        for (int i = 0; i < 3; i++)
        begin
            for (int j = 0; j < 8; j++)
            begin
                check_line(expected_delta(left_mem[40 + j], right_mem[140 + j], 1'b0),
                           out_mem[260 + i * 8 + j], "iterated delta line");
            end
        end
        check_count(24, write_count - writes_before, "iteration write count");
        finish_test("iterations", errors_before);
    endtask

    task automatic test_saturation();
        int errors_before;
        errors_before = error_count;
        left_mem[300]  = make_line(32767, -32768, 30000, 5);
        right_mem[302] = make_line(-1, 1, -10000, 3);
        left_mem[301]  = make_line(-20000, 100, -32768, 32767);
        right_mem[303] = make_line(20000, -100, -32768, 32767);
        run_command('{num_lines: 2, num_iterations: 1, left_base: 300, right_base: 302,
                      out_base: 400, do_sigmoid: 1'b0}, 1);
        check_line(make_line(32767, -32768, 32767, 2), out_mem[400], "saturated line 0");
        check_line(make_line(-32768, 200, 0, 0), out_mem[401], "saturated line 1");
        finish_test("saturation", errors_before);
    endtask

    task automatic test_zero_lines();
        int errors_before;
        int writes_before;
        int reads_before;
        errors_before = error_count;
        writes_before = write_count;
        reads_before  = read_count;
        cmd = '{num_lines: 0, num_iterations: 4, left_base: 0, right_base: 0,
                out_base: 420, do_sigmoid: 1'b0};
        req = 1'b1;
        step_cycle();
        check_ack(1'b0, ack, "ack one cycle after req");
        step_cycle();
        check_ack(1'b1, ack, "ack two cycles after req");
        req = 1'b0;
        wait_for_ack(1'b0);
        check_count(0, write_count - writes_before, "zero command write count");
        check_count(0, read_count - reads_before, "zero command read count");
        check_line(fill_pattern(10'd420), out_mem[420], "untouched output line");
        finish_test("zero_lines", errors_before);
    endtask

    task automatic test_handshake();
        int errors_before;
        errors_before = error_count;
        run_command('{num_lines: 6, num_iterations: 1, left_base: 60, right_base: 160,
                      out_base: 440, do_sigmoid: 1'b0}, 5);
        run_command('{num_lines: 6, num_iterations: 1, left_base: 70, right_base: 170,
                      out_base: 460, do_sigmoid: 1'b1}, 1);
        for (int j = 0; j < 6; j++)
        begin
            check_line(expected_delta(left_mem[60 + j], right_mem[160 + j], 1'b0),
                       out_mem[440 + j], "first handshake line");
            check_line(expected_delta(left_mem[70 + j], right_mem[170 + j], 1'b1),
                       out_mem[460 + j], "second handshake line");
        end
        finish_test("handshake", errors_before);
    endtask

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        req         = 1'b0;
        cmd         = '0;
        left_rdata  = '0;
        right_rdata = '0;
        lfsr_state  = 32'h51f4_394a;
        write_count  = 0;
        read_count   = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_passed = 0;
        for (int a = 0; a < mem_lines; a++)
        begin
            random_line(left_mem[a]);
            random_line(right_mem[a]);
            out_mem[a] = fill_pattern(addr_t'(a));
        end
        repeat (3) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        test_bypass();
        test_sigmoid();
        test_iterations();
        test_saturation();
        test_zero_lines();
        test_handshake();

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_passed, tests_run - tests_passed, error_count);
        if (error_count == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
